// ==== rtl/node_pkg.sv ====
// routing node topology constants
// arbiter state type

package node_pkg;

   // ------------------------------------------------------------
   // port counts
   // ------------------------------------------------------------
   localparam int N_SLV    = 2;  // initiator side ports
   localparam int N_MST    = 4;  // target side ports
   localparam int N_REGION = 2;  // address regions per target

   // ------------------------------------------------------------
   // address channel widths
   // ------------------------------------------------------------
   localparam int ADDR_W    = 32;
   localparam int ID_IN_W   = 4;                    // id as seen by an initiator
   localparam int SLV_IDX_W = 1;                    // enough bits for N_SLV
   localparam int ID_OUT_W  = ID_IN_W + SLV_IDX_W;  // initiator index prepended

   // output register of a target arbiter
   typedef enum logic {
      ARB_IDLE = 1'b0,  // register empty, may grant
      ARB_HOLD = 1'b1   // request offered to the target
   } arb_state_e;

endpackage

// ==== rtl/node_cfg_pkg.sv ====
// configuration register map
// and default memory map

package node_cfg_pkg;

   import node_pkg::*;

   localparam int CFG_ADDR_W = 5;   // 2 field bits, 3 index bits
   localparam int CFG_DATA_W = 32;

   // high bits of the cfg address
   typedef enum logic [1:0] {
      FLD_START = 2'd0,  // region start, index = region*N_MST + target
      FLD_END   = 2'd1,  // region end, same indexing
      FLD_VALID = 2'd2,  // region enable in data bit 0
      FLD_CONN  = 2'd3   // connectivity row, index = initiator, one bit per target
   } cfg_field_e;

   // ------------------------------------------------------------
   // reset map: region 0 of target m is a 4k window at m*0x1000
   // region 1 disabled
   // ------------------------------------------------------------
   localparam logic [CFG_DATA_W-1:0] DEF_START [N_REGION*N_MST] = '{
      32'h0000_0000, 32'h0000_1000, 32'h0000_2000, 32'h0000_3000,
      32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000
   };

   localparam logic [CFG_DATA_W-1:0] DEF_END [N_REGION*N_MST] = '{
      32'h0000_0FFF, 32'h0000_1FFF, 32'h0000_2FFF, 32'h0000_3FFF,
      32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000
   };

   localparam logic [CFG_DATA_W-1:0] DEF_VALID [N_REGION*N_MST] = '{
      32'd1, 32'd1, 32'd1, 32'd1,
      32'd0, 32'd0, 32'd0, 32'd0
   };

   localparam logic [CFG_DATA_W-1:0] DEF_CONN [N_SLV] = '{32'h0000_000F, 32'h0000_000F};

endpackage

// ==== rtl/cfg_regs.sv ====
// memory map registers

`timescale 1ns/100ps

module cfg_regs import node_pkg::*, node_cfg_pkg::*; (
   input  logic                                 clk,
   input  logic                                 arst_n_i,
   input  logic                                 cfg_we_i,     // write strobe
   input  logic                                 cfg_re_i,     // read strobe
   input  logic [CFG_ADDR_W-1:0]                cfg_addr_i,
   input  logic [CFG_DATA_W-1:0]                cfg_wdata_i,
   output logic [CFG_DATA_W-1:0]                cfg_rdata_o,
   output logic                                 cfg_rvalid_o, // one cycle after cfg_re_i
   output logic [N_REGION-1:0][N_MST-1:0][ADDR_W-1:0] start_addr_o,
   output logic [N_REGION-1:0][N_MST-1:0][ADDR_W-1:0] end_addr_o,
   output logic [N_REGION-1:0][N_MST-1:0]       valid_rule_o,
   output logic [N_SLV-1:0][N_MST-1:0]          conn_map_o
);

   cfg_field_e                  fld;
   logic [CFG_ADDR_W-3:0]       idx;       // region*N_MST + target, or initiator
   logic [CFG_DATA_W-1:0]       rdata_d;

   assign fld = cfg_field_e'(cfg_addr_i[CFG_ADDR_W-1:CFG_ADDR_W-2]);
   assign idx = cfg_addr_i[CFG_ADDR_W-3:0];

   // ------------------------------------------------------------
   // map storage, defaults from the package at reset
   // ------------------------------------------------------------
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int r = 0; r < N_REGION; r++) begin
            for (int m = 0; m < N_MST; m++) begin
               start_addr_o[r][m] <= DEF_START[r*N_MST+m];
               end_addr_o[r][m]   <= DEF_END[r*N_MST+m];
               valid_rule_o[r][m] <= DEF_VALID[r*N_MST+m][0];
            end
         end
         for (int s = 0; s < N_SLV; s++) begin
            conn_map_o[s] <= DEF_CONN[s][N_MST-1:0];
         end
      end else if (cfg_we_i) begin
         for (int r = 0; r < N_REGION; r++) begin
            for (int m = 0; m < N_MST; m++) begin
               if (int'(idx) == r*N_MST + m) begin  // every address index is in range
                  if (fld == FLD_START) start_addr_o[r][m] <= cfg_wdata_i;
                  if (fld == FLD_END)   end_addr_o[r][m]   <= cfg_wdata_i;
                  if (fld == FLD_VALID) valid_rule_o[r][m] <= cfg_wdata_i[0];
               end
            end
         end
         for (int s = 0; s < N_SLV; s++) begin
            if (fld == FLD_CONN && int'(idx) == s)
               conn_map_o[s] <= cfg_wdata_i[N_MST-1:0];  // upper index values dropped
         end
      end
   end

   // read mux, unmatched index reads zero
   always_comb begin
      rdata_d = '0;
      for (int r = 0; r < N_REGION; r++) begin
         for (int m = 0; m < N_MST; m++) begin
            if (int'(idx) == r*N_MST + m) begin
               case (fld)
                  FLD_START: rdata_d = start_addr_o[r][m];
                  FLD_END:   rdata_d = end_addr_o[r][m];
                  FLD_VALID: rdata_d = {{(CFG_DATA_W-1){1'b0}}, valid_rule_o[r][m]};
                  default:   ;                                 // conn handled below
               endcase
            end
         end
      end
      for (int s = 0; s < N_SLV; s++) begin
         if (fld == FLD_CONN && int'(idx) == s)
            rdata_d = {{(CFG_DATA_W-N_MST){1'b0}}, conn_map_o[s]};
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) cfg_rvalid_o <= 1'b0;
      else           cfg_rvalid_o <= cfg_re_i;
   end

   always_ff @(posedge clk) begin
      if (cfg_re_i) cfg_rdata_o <= rdata_d;  // held until the next read
   end

endmodule

// ==== rtl/addr_decoder.sv ====
// initiator address decoder

`timescale 1ns/100ps

module addr_decoder import node_pkg::*; (
   input  logic                                   clk,
   input  logic                                   arst_n_i,
   // initiator address channel
   input  logic                                   slave_valid_i,
   input  logic [ADDR_W-1:0]                      slave_addr_i,
   input  logic [ID_IN_W-1:0]                     slave_id_i,
   output logic                                   slave_ready_o,
   output logic                                   slave_err_o,     // one cycle after err transfer
   output logic [ID_IN_W-1:0]                     slave_err_id_o,
   // map from the register block
   input  logic [N_REGION-1:0][N_MST-1:0][ADDR_W-1:0] start_addr_i,
   input  logic [N_REGION-1:0][N_MST-1:0][ADDR_W-1:0] end_addr_i,
   input  logic [N_REGION-1:0][N_MST-1:0]         valid_rule_i,
   input  logic [N_MST-1:0]                       conn_map_i,      // this initiator's row
   // towards the target arbiters
   output logic [N_MST-1:0]                       req_o,
   input  logic [N_MST-1:0]                       gnt_i
);

   logic [N_MST-1:0] hit;      // targets with a matching enabled region
   logic [N_MST-1:0] sel;      // lowest hit only
   logic [N_MST-1:0] route;    // sel after connectivity mask
   logic             dec_err;

   // ------------------------------------------------------------
   // region match
   // ------------------------------------------------------------
   always_comb begin
      hit = '0;
      for (int r = 0; r < N_REGION; r++) begin
         for (int m = 0; m < N_MST; m++) begin
            if (valid_rule_i[r][m] && slave_addr_i >= start_addr_i[r][m]
                && slave_addr_i <= end_addr_i[r][m])
               hit[m] = 1'b1;
         end
      end
   end

   assign sel     = hit & (~hit + 1'b1);  // isolate lowest set bit
   assign route   = sel & conn_map_i;     // blocked target -> no route
   assign dec_err = ~|route;

   assign req_o = slave_valid_i ? route : '0;

   // decode errors are accepted locally, routed ones wait for the grant
   assign slave_ready_o = slave_valid_i & (dec_err | (|(gnt_i & route)));

   // error response strobe
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) slave_err_o <= 1'b0;
      else           slave_err_o <= slave_valid_i & dec_err;
   end

   always_ff @(posedge clk) begin
      if (slave_valid_i && dec_err) slave_err_id_o <= slave_id_i;
   end

endmodule

// ==== rtl/target_arbiter.sv ====
// per target round robin arbiter

`timescale 1ns/100ps

module target_arbiter import node_pkg::*; (
   input  logic                          clk,
   input  logic                          arst_n_i,
   input  logic [N_SLV-1:0]              req_i,          // one bit per initiator
   output logic [N_SLV-1:0]              gnt_o,          // same cycle as req_i
   input  logic [N_SLV-1:0][ADDR_W-1:0]  slave_addr_i,
   input  logic [N_SLV-1:0][ID_IN_W-1:0] slave_id_i,
   output logic                          master_valid_o,
   output logic [ADDR_W-1:0]             master_addr_o,
   output logic [ID_OUT_W-1:0]           master_id_o,    // {initiator, id}
   input  logic                          master_ready_i
);

   arb_state_e            state_q;
   logic [SLV_IDX_W-1:0]  last_q;    // last winner
   logic [SLV_IDX_W-1:0]  cand;
   logic [SLV_IDX_W-1:0]  win;
   logic                  any;
   logic                  take;      // grant issued this cycle

   // ------------------------------------------------------------
   // round robin pick, starting one past the last winner
   // ------------------------------------------------------------
   always_comb begin
      win = last_q;
      any = 1'b0;
      cand = last_q;
      for (int k = 1; k <= N_SLV; k++) begin
         cand = SLV_IDX_W'((int'(last_q) + k) % N_SLV);
         if (!any && req_i[cand]) begin
            win = cand;
            any = 1'b1;
         end
      end
   end

   assign take = (state_q == ARB_IDLE) & any;  // no grant while holding

   always_comb begin
      gnt_o = '0;
      for (int s = 0; s < N_SLV; s++) begin
         if (take && int'(win) == s) gnt_o[s] = 1'b1;
      end
   end

   // FSM and winner pointer
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= ARB_IDLE;
         last_q  <= SLV_IDX_W'(N_SLV-1);  // initiator 0 goes first
      end else begin
         case (state_q)
            ARB_IDLE: if (any) begin
               state_q <= ARB_HOLD;
               last_q  <= win;
            end
            ARB_HOLD: if (master_ready_i) state_q <= ARB_IDLE;  // target took it
            default:  state_q <= ARB_IDLE;
         endcase
      end
   end

   assign master_valid_o = (state_q == ARB_HOLD);

   always_ff @(posedge clk) begin
      if (take) begin
         master_addr_o <= slave_addr_i[win];
         master_id_o   <= {win, slave_id_i[win]};  // initiator index prepended
      end
   end

endmodule

// ==== rtl/node_top.sv ====
// address routing node
// top level

`timescale 1ns/100ps

module node_top import node_pkg::*, node_cfg_pkg::*; (
   input  logic                               clk,
   input  logic                               arst_n_i,
   // initiator side
   input  logic [N_SLV-1:0]                   slave_valid_i,
   input  logic [N_SLV-1:0][ADDR_W-1:0]       slave_addr_i,
   input  logic [N_SLV-1:0][ID_IN_W-1:0]      slave_id_i,
   output logic [N_SLV-1:0]                   slave_ready_o,
   output logic [N_SLV-1:0]                   slave_err_o,     // decode error strobe
   output logic [N_SLV-1:0][ID_IN_W-1:0]      slave_err_id_o,
   // target side
   output logic [N_MST-1:0]                   master_valid_o,
   output logic [N_MST-1:0][ADDR_W-1:0]       master_addr_o,
   output logic [N_MST-1:0][ID_OUT_W-1:0]     master_id_o,
   input  logic [N_MST-1:0]                   master_ready_i,
   // configuration strobes
   input  logic                               cfg_we_i,
   input  logic                               cfg_re_i,
   input  logic [CFG_ADDR_W-1:0]              cfg_addr_i,
   input  logic [CFG_DATA_W-1:0]              cfg_wdata_i,
   output logic [CFG_DATA_W-1:0]              cfg_rdata_o,
   output logic                               cfg_rvalid_o
);

   logic [N_SLV-1:0][N_MST-1:0]               req;     // decoder view
   logic [N_MST-1:0][N_SLV-1:0]               req_t;   // arbiter view
   logic [N_MST-1:0][N_SLV-1:0]               gnt;     // arbiter view
   logic [N_SLV-1:0][N_MST-1:0]               gnt_t;   // decoder view

   logic [N_REGION-1:0][N_MST-1:0][ADDR_W-1:0] start_addr;
   logic [N_REGION-1:0][N_MST-1:0][ADDR_W-1:0] end_addr;
   logic [N_REGION-1:0][N_MST-1:0]             valid_rule;
   logic [N_SLV-1:0][N_MST-1:0]                conn_map;

   // ------------------------------------------------------------
   // request / grant matrix transpose
   // ------------------------------------------------------------
   for (genvar s = 0; s < N_SLV; s++) begin : g_transpose_slv
      for (genvar m = 0; m < N_MST; m++) begin : g_transpose_mst
         assign req_t[m][s] = req[s][m];
         assign gnt_t[s][m] = gnt[m][s];
      end
   end

   cfg_regs cfg_regs_i (
      .clk(clk), .arst_n_i(arst_n_i),
      .cfg_we_i(cfg_we_i), .cfg_re_i(cfg_re_i), .cfg_addr_i(cfg_addr_i),
      .cfg_wdata_i(cfg_wdata_i), .cfg_rdata_o(cfg_rdata_o), .cfg_rvalid_o(cfg_rvalid_o),
      .start_addr_o(start_addr), .end_addr_o(end_addr),
      .valid_rule_o(valid_rule), .conn_map_o(conn_map)
   );

   for (genvar s = 0; s < N_SLV; s++) begin : g_dec  // one decoder per initiator
      addr_decoder addr_decoder_i (
         .clk(clk), .arst_n_i(arst_n_i),
         .slave_valid_i(slave_valid_i[s]), .slave_addr_i(slave_addr_i[s]),
         .slave_id_i(slave_id_i[s]), .slave_ready_o(slave_ready_o[s]),
         .slave_err_o(slave_err_o[s]), .slave_err_id_o(slave_err_id_o[s]),
         .start_addr_i(start_addr), .end_addr_i(end_addr),
         .valid_rule_i(valid_rule), .conn_map_i(conn_map[s]),
         .req_o(req[s]), .gnt_i(gnt_t[s])
      );
   end

   for (genvar m = 0; m < N_MST; m++) begin : g_arb  // one arbiter per target
      target_arbiter target_arbiter_i (
         .clk(clk), .arst_n_i(arst_n_i),
         .req_i(req_t[m]), .gnt_o(gnt[m]),
         .slave_addr_i(slave_addr_i), .slave_id_i(slave_id_i),
         .master_valid_o(master_valid_o[m]), .master_addr_o(master_addr_o[m]),
         .master_id_o(master_id_o[m]), .master_ready_i(master_ready_i[m])
      );
   end

endmodule

// ==== testbench/node_asserts.sv ====
// handshake assertions for the routing node

`timescale 1ns/100ps

module node_asserts import node_pkg::*; (
   input logic                              clk_i,
   input logic                              arst_n_i,
   input logic [N_MST-1:0]                  master_valid_i,
   input logic [N_MST-1:0]                  master_ready_i,
   input logic [N_MST-1:0][ADDR_W-1:0]      master_addr_i,
   input logic [N_SLV-1:0]                  slave_err_i,
   input logic [N_MST-1:0][N_SLV-1:0]       gnt_i        // arbiter view
);

   for (genvar m = 0; m < N_MST; m++) begin : g_mst
      a_valid_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
         master_valid_i[m] && !master_ready_i[m] |=> master_valid_i[m])
         else $error("target %0d dropped valid before ready", m);
      a_addr_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
         master_valid_i[m] && !master_ready_i[m] |=> $stable(master_addr_i[m]))
         else $error("target %0d address changed while held", m);
      a_one_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
         $onehot0(gnt_i[m]))
         else $error("target %0d granted more than one initiator", m);
   end

   for (genvar s = 0; s < N_SLV; s++) begin : g_slv
      a_err_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
         slave_err_i[s] |=> !slave_err_i[s])
         else $error("initiator %0d error strobe longer than one cycle", s);
   end

endmodule

// ==== testbench/tb_checker.sv ====
// reference model and output comparison

`timescale 1ns/100ps

module tb_checker import node_pkg::*, node_cfg_pkg::*; (
   input  logic                             clk_i,
   input  logic                             arst_n_i,
   input  logic [N_SLV-1:0]                 slave_valid_i,
   input  logic [N_SLV-1:0]                 slave_ready_i,
   input  logic [N_SLV-1:0]                 slave_err_i,
   input  logic [N_SLV-1:0][ADDR_W-1:0]     slave_addr_i,
   input  logic [N_SLV-1:0][ID_IN_W-1:0]    slave_id_i,
   input  logic [N_SLV-1:0][ID_IN_W-1:0]    slave_err_id_i,
   input  logic [N_MST-1:0]                 master_valid_i,
   input  logic [N_MST-1:0]                 master_ready_i,
   input  logic [N_MST-1:0][ADDR_W-1:0]     master_addr_i,
   input  logic [N_MST-1:0][ID_OUT_W-1:0]   master_id_i,
   input  logic                             cfg_we_i,
   input  logic                             cfg_re_i,
   input  logic [CFG_ADDR_W-1:0]            cfg_addr_i,
   input  logic [CFG_DATA_W-1:0]            cfg_wdata_i,
   input  logic [CFG_DATA_W-1:0]            cfg_rdata_i,
   input  logic                             cfg_rvalid_i,
   output int                               err_count_o
);

   logic [31:0]         m_start [N_REGION*N_MST];  // model map, index region*N_MST + target
   logic [31:0]         m_end   [N_REGION*N_MST];
   logic                m_valid [N_REGION*N_MST];
   logic [N_MST-1:0]    m_conn  [N_SLV];
   logic                hold    [N_MST];           // target owes a request
   logic [ADDR_W-1:0]   exp_addr [N_MST];
   logic [ID_OUT_W-1:0] exp_id   [N_MST];
   int                  last_win [N_MST];
   logic                err_due  [N_SLV];
   logic [ID_IN_W-1:0]  exp_err_id [N_SLV];
   logic                rd_due;
   logic [31:0]         rd_exp;

   initial err_count_o = 0;

   // lowest enabled region hit, then the connectivity mask
   function automatic int route_of(input int s, input logic [31:0] a);
      int hit;
      hit = -1;
      for (int m = N_MST-1; m >= 0; m--) begin
         for (int r = 0; r < N_REGION; r++) begin
            if (m_valid[r*N_MST+m] && a >= m_start[r*N_MST+m] && a <= m_end[r*N_MST+m])
               hit = m;  // descending, so lowest wins
         end
      end
      if (hit >= 0 && !m_conn[s][hit]) hit = -1;
      return hit;
   endfunction

   function automatic logic [31:0] read_model(input logic [4:0] a);
      int idx;
      idx = int'(a[2:0]);
      case (a[4:3])
         2'd0:    return m_start[idx];
         2'd1:    return m_end[idx];
         2'd2:    return {31'b0, m_valid[idx]};
         default: return (idx < N_SLV) ? {28'b0, m_conn[idx % N_SLV]} : 32'b0;
      endcase
   endfunction

   task automatic mismatch(input string name, input logic [31:0] e, input logic [31:0] a);
      $display("FAIL %s expected %h got %h", name, e, a);
      err_count_o++;
   endtask

   task automatic problem(input string what);
      $display("%s", what);
      err_count_o++;
   endtask

   // ------------------------------------------------------------
   // compare at each rising edge, then predict the next cycle
   // ------------------------------------------------------------
   always @(posedge clk_i or negedge arst_n_i) begin : watch
      int t;
      int other;
      if (!arst_n_i) begin
         for (int i = 0; i < N_REGION*N_MST; i++) begin
            m_start[i] = (i < N_MST) ? 32'(i) * 32'h1000 : 32'h0;  // 4k window per target
            m_end[i]   = (i < N_MST) ? 32'(i) * 32'h1000 + 32'h0FFF : 32'h0;
            m_valid[i] = (i < N_MST);
         end
         for (int s = 0; s < N_SLV; s++) begin
            m_conn[s]  = '1;
            err_due[s] = 1'b0;
         end
         for (int m = 0; m < N_MST; m++) begin
            hold[m]     = 1'b0;
            last_win[m] = N_SLV-1;   // initiator 0 first
         end
         rd_due = 1'b0;
      end else begin
         for (int m = 0; m < N_MST; m++) begin
            if (master_valid_i[m]) begin
               if (!hold[m]) begin
                  problem($sformatf("target %0d offered a request no initiator sent", m));
               end else begin
                  if (master_addr_i[m] !== exp_addr[m])
                     mismatch($sformatf("master_addr_o[%0d]", m), exp_addr[m], master_addr_i[m]);
                  if (master_id_i[m] !== exp_id[m])
                     mismatch($sformatf("master_id_o[%0d]", m), 32'(exp_id[m]), 32'(master_id_i[m]));
                  if (master_ready_i[m]) hold[m] = 1'b0;  // target took it
               end
            end else if (hold[m]) begin
               problem($sformatf("target %0d did not offer its request", m));
               hold[m] = 1'b0;
            end
         end
         for (int s = 0; s < N_SLV; s++) begin
            if (slave_err_i[s] !== err_due[s])
               mismatch($sformatf("slave_err_o[%0d]", s), 32'(err_due[s]), 32'(slave_err_i[s]));
            else if (err_due[s] && slave_err_id_i[s] !== exp_err_id[s])
               mismatch($sformatf("slave_err_id_o[%0d]", s), 32'(exp_err_id[s]),
                        32'(slave_err_id_i[s]));
         end
         if (cfg_rvalid_i !== rd_due)
            mismatch("cfg_rvalid_o", 32'(rd_due), 32'(cfg_rvalid_i));
         else if (rd_due && cfg_rdata_i !== rd_exp)
            mismatch("cfg_rdata_o", rd_exp, cfg_rdata_i);
         rd_due = cfg_re_i;   // read sees the map before a same-cycle write
         if (cfg_re_i) rd_exp = read_model(cfg_addr_i);
         // initiator transfers on this edge
         for (int s = 0; s < N_SLV; s++) begin
            err_due[s] = 1'b0;
            if (slave_valid_i[s] && slave_ready_i[s]) begin
               t = route_of(s, slave_addr_i[s]);
               if (t < 0) begin
                  err_due[s]    = 1'b1;
                  exp_err_id[s] = slave_id_i[s];
               end else begin
                  other = N_SLV-1-s;
                  if (slave_valid_i[other] && route_of(other, slave_addr_i[other]) == t
                      && s != (last_win[t] + 1) % N_SLV)
                     problem($sformatf("target %0d granted initiator %0d out of turn", t, s));
                  if (hold[t])
                     problem($sformatf("target %0d took a second request while full", t));
                  hold[t]     = 1'b1;
                  exp_addr[t] = slave_addr_i[s];
                  exp_id[t]   = {SLV_IDX_W'(s), slave_id_i[s]};  // index then id
                  last_win[t] = s;
               end
            end
         end
         if (cfg_we_i) begin
            case (cfg_addr_i[4:3])
               2'd0: m_start[cfg_addr_i[2:0]] = cfg_wdata_i;
               2'd1: m_end[cfg_addr_i[2:0]]   = cfg_wdata_i;
               2'd2: m_valid[cfg_addr_i[2:0]] = cfg_wdata_i[0];
               default: if (int'(cfg_addr_i[2:0]) < N_SLV)
                  m_conn[int'(cfg_addr_i[2:0]) % N_SLV] = cfg_wdata_i[N_MST-1:0];
            endcase
         end
      end
   end

endmodule

// ==== testbench/tb_top.sv ====
// routing node testbench

`timescale 1ns/100ps

module tb_top import node_pkg::*, node_cfg_pkg::*; ();

   typedef enum {S_WR, S_RD, S_REQ, S_PAIR} step_kind_e;
   typedef struct {
      step_kind_e   kind;
      int           slv;
      logic [3:0]   id;
      logic [31:0]  addr;   // cfg address or request base
      logic [31:0]  data;   // write word, expected word or offset mask
   } step_t;

   logic                            clk;
   logic                            arst_n;
   logic [N_SLV-1:0]                slave_valid;
   logic [N_SLV-1:0][ADDR_W-1:0]    slave_addr;
   logic [N_SLV-1:0][ID_IN_W-1:0]   slave_id;
   logic [N_SLV-1:0]                slave_ready, slave_err;
   logic [N_SLV-1:0][ID_IN_W-1:0]   slave_err_id;
   logic [N_MST-1:0]                master_valid, master_ready;
   logic [N_MST-1:0][ADDR_W-1:0]    master_addr;
   logic [N_MST-1:0][ID_OUT_W-1:0]  master_id;
   logic                            cfg_we, cfg_re, cfg_rvalid;
   logic [CFG_ADDR_W-1:0]           cfg_addr;
   logic [CFG_DATA_W-1:0]           cfg_wdata, cfg_rdata;

   step_t  tbl[$];
   int     seed = 16;
   int     errors = 0;
   int     chk_errors;
   logic   pair_done;
   logic [31:0] a;

   always #10 clk = ~clk;  // 20 ns period

   node_top node_top_i (
      .clk(clk), .arst_n_i(arst_n),
      .slave_valid_i(slave_valid), .slave_addr_i(slave_addr), .slave_id_i(slave_id),
      .slave_ready_o(slave_ready), .slave_err_o(slave_err), .slave_err_id_o(slave_err_id),
      .master_valid_o(master_valid), .master_addr_o(master_addr), .master_id_o(master_id),
      .master_ready_i(master_ready),
      .cfg_we_i(cfg_we), .cfg_re_i(cfg_re), .cfg_addr_i(cfg_addr), .cfg_wdata_i(cfg_wdata),
      .cfg_rdata_o(cfg_rdata), .cfg_rvalid_o(cfg_rvalid)
   );

   tb_checker tb_checker_i (
      .clk_i(clk), .arst_n_i(arst_n),
      .slave_valid_i(slave_valid), .slave_ready_i(slave_ready), .slave_err_i(slave_err),
      .slave_addr_i(slave_addr), .slave_id_i(slave_id), .slave_err_id_i(slave_err_id),
      .master_valid_i(master_valid), .master_ready_i(master_ready),
      .master_addr_i(master_addr), .master_id_i(master_id),
      .cfg_we_i(cfg_we), .cfg_re_i(cfg_re), .cfg_addr_i(cfg_addr), .cfg_wdata_i(cfg_wdata),
      .cfg_rdata_i(cfg_rdata), .cfg_rvalid_i(cfg_rvalid), .err_count_o(chk_errors)
   );

   bind node_top node_asserts node_asserts_i (
      .clk_i(clk), .arst_n_i(arst_n_i), .master_valid_i(master_valid_o),
      .master_ready_i(master_ready_i), .master_addr_i(master_addr_o),
      .slave_err_i(slave_err_o), .gnt_i(gnt)
   );

   // ------------------------------------------------------------
   // drivers, all inputs change on the falling edge
   // ------------------------------------------------------------
   task automatic request(input int s, input logic [3:0] id, input logic [31:0] addr);
      int   n;
      logic got;
      got = 1'b0;
      @(negedge clk);
      slave_valid[s] = 1'b1;
      slave_addr[s]  = addr;
      slave_id[s]    = id;
      for (n = 0; n < 60 && !got; n++) begin
         #5 got = slave_ready[s];  // transfer on the coming rising edge
         @(negedge clk);
      end
      slave_valid[s] = 1'b0;
      if (!got) begin
         $display("timeout: initiator %0d never accepted address %h", s, addr);
         errors++;
      end
   endtask

   task automatic cfg_write(input logic [4:0] ca, input logic [31:0] d);
      @(negedge clk);
      cfg_we    = 1'b1;
      cfg_addr  = ca;
      cfg_wdata = d;
      @(negedge clk);
      cfg_we    = 1'b0;
   endtask

   task automatic cfg_read(input logic [4:0] ca, input logic [31:0] exp);
      int   n;
      logic got;
      got = 1'b0;
      @(negedge clk);
      cfg_re   = 1'b1;
      cfg_addr = ca;
      @(negedge clk);
      cfg_re   = 1'b0;
      for (n = 0; n < 10 && !got; n++) begin
         #5 got = cfg_rvalid;
         if (!got) @(negedge clk);
      end
      if (!got) begin
         $display("timeout: no read-back strobe for config address %h", ca);
         errors++;
      end else if (cfg_rdata !== exp) begin
         $display("FAIL cfg_rdata_o expected %h got %h", exp, cfg_rdata);
         errors++;
      end
   endtask

   // both initiators on one target, target stalls for random lengths
   task automatic contend(input int m, input logic [3:0] id, input logic [31:0] base,
                          input logic [31:0] mask);
      int n;
      pair_done = 1'b0;
      fork
         begin
            fork
               request(0, id, base | ($random(seed) & mask));
               request(1, id + 4'd1, base | ($random(seed) & mask));
            join
            pair_done = 1'b1;
         end
         for (n = 0; n < 30 && !pair_done; n++) begin
            @(negedge clk);
            master_ready[m] = 1'b0;
            repeat ($unsigned($random(seed)) % 4) @(negedge clk);
            master_ready[m] = 1'b1;
         end
      join
      @(negedge clk);
      master_ready[m] = 1'b1;
   endtask

   initial begin : main
      int n;
      clk = 1'b0;
      arst_n = 1'b0;
      slave_valid = '0;
      slave_addr = '0;
      slave_id = '0;
      master_ready = '1;
      cfg_we = 1'b0;
      cfg_re = 1'b0;
      cfg_addr = '0;
      cfg_wdata = '0;
      // default routing, every initiator to every target
      for (int m = 0; m < N_MST; m++)
         for (int s = 0; s < N_SLV; s++)
            tbl.push_back('{S_REQ, s, 4'(m*2+s), 32'(m) * 32'h1000, 32'h0FFF});
      // region 1 of target 2 at 0x10000, read back, then use it
      tbl.push_back('{S_WR, 0, 4'h0, 32'h06, 32'h0001_0000});
      tbl.push_back('{S_WR, 0, 4'h0, 32'h0E, 32'h0001_00FF});
      tbl.push_back('{S_WR, 0, 4'h0, 32'h16, 32'h1});
      tbl.push_back('{S_RD, 0, 4'h0, 32'h06, 32'h0001_0000});
      tbl.push_back('{S_RD, 0, 4'h0, 32'h0E, 32'h0001_00FF});
      tbl.push_back('{S_RD, 0, 4'h0, 32'h16, 32'h1});
      tbl.push_back('{S_REQ, 0, 4'h7, 32'h0001_0000, 32'h00FF});
      tbl.push_back('{S_REQ, 1, 4'hA, 32'h8000_0000, 32'h0FFF});  // unmapped
      // initiator 0 loses target 1
      tbl.push_back('{S_WR, 0, 4'h0, 32'h18, 32'hD});
      tbl.push_back('{S_RD, 0, 4'h0, 32'h18, 32'hD});
      tbl.push_back('{S_REQ, 0, 4'h3, 32'h0000_1000, 32'h0FFF});
      tbl.push_back('{S_REQ, 1, 4'h5, 32'h0000_1000, 32'h0FFF});
      for (int k = 0; k < 4; k++) begin
         // solo request sets the last winner, so the first grant of each pair alternates
         tbl.push_back('{S_REQ, 1 - k % 2, 4'(12+k), 32'h0000_3000, 32'h0FFF});
         tbl.push_back('{S_PAIR, 3, 4'(k*2), 32'h0000_3000, 32'h0FFF});
      end

      repeat (3) @(negedge clk);
      arst_n = 1'b1;

      foreach (tbl[i]) begin
         case (tbl[i].kind)
            S_WR:  cfg_write(tbl[i].addr[4:0], tbl[i].data);
            S_RD:  cfg_read(tbl[i].addr[4:0], tbl[i].data);
            S_REQ: begin
               a = tbl[i].addr | ($random(seed) & tbl[i].data);
               request(tbl[i].slv, tbl[i].id, a);
            end
            default: contend(tbl[i].slv, tbl[i].id, tbl[i].addr, tbl[i].data);
         endcase
      end

      // drain the targets and the last error strobe
      for (n = 0; n < 20 && (|master_valid); n++) @(negedge clk);
      if (|master_valid) begin
         $display("timeout: targets still holding requests at the end");
         errors++;
      end
      repeat (2) @(negedge clk);

      $display("errors: testbench %0d, checker %0d", errors, chk_errors);
      if (errors == 0 && chk_errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

// ==== all.f ====
rtl/node_pkg.sv
rtl/node_cfg_pkg.sv
rtl/cfg_regs.sv
rtl/addr_decoder.sv
rtl/target_arbiter.sv
rtl/node_top.sv
testbench/node_asserts.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the routing node testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_top -Mdir obj_dir -o tb_sim -f all.f
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Some tests failed" sim.log; then
   exit 1
fi
exit 0
